// File: logic/arb_pkg.sv
package arb_pkg;

	// Who owns the cache port
	typedef enum logic [1:0]
	{
		arb_instr = 2'd0,	// Fetch connected
		arb_wait  = 2'd1,	// Data op waiting for fetch to drain
		arb_mem   = 2'd2	// Data memory connected
	} arb_state_e;

	// Arbiter status bundle
	typedef struct packed
	{
		arb_state_e state;
		logic       stall_mem;	// Hold issue while waiting
		logic       arb_eqmem;	// Data side owns the port
	} arb_status_t;

endpackage

// File: logic/cache_port_share.sv
module cache_port_share
#(
	parameter int PC_W = 32
)
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              mem_pending,
	input  logic              hold,
	input  logic              fetch_waiting,
	input  logic              mem_op_done,
	input  l15_pkg::l15_req_t fetch_req,
	input  l15_pkg::l15_req_t mem_req,
	input  logic              fetch_req_ack,
	input  logic              mem_req_ack,
	input  l15_pkg::l15_ack_t l15_ack,
	input  l15_pkg::l15_rsp_t l15_rsp,
	input  logic [PC_W-1:0]   commit_pc,
	output l15_pkg::l15_req_t l15_req,
	output logic              l15_req_ack,
	output l15_pkg::l15_ack_t fetch_ack,
	output l15_pkg::l15_rsp_t fetch_rsp,
	output l15_pkg::l15_ack_t mem_ack,
	output l15_pkg::l15_rsp_t mem_rsp,
	output logic              stall_mem,
	output logic              arb_eqmem,
	output logic              dmem_finished,
	output logic              commit
);
	import arb_pkg::*;

	arb_status_t status;	// From arbiter to router and outputs

	// Decides ownership of the single port
	port_arbiter u_arbiter
	(
		.clk           (clk),
		.nrst          (nrst),
		.mem_pending   (mem_pending),
		.hold          (hold),
		.fetch_waiting (fetch_waiting),
		.mem_op_done   (mem_op_done),
		.l15_rsp_val   (l15_rsp.val),
		.l15_ack       (l15_ack),
		.status        (status),
		.dmem_finished (dmem_finished)
	);

	// Steers the port to the owner
	port_router u_router
	(
		.state         (status.state),
		.fetch_req     (fetch_req),
		.mem_req       (mem_req),
		.fetch_req_ack (fetch_req_ack),
		.mem_req_ack   (mem_req_ack),
		.l15_ack       (l15_ack),
		.l15_rsp       (l15_rsp),
		.l15_req       (l15_req),
		.fetch_ack     (fetch_ack),
		.mem_ack       (mem_ack),
		.fetch_rsp     (fetch_rsp),
		.mem_rsp       (mem_rsp),
		.l15_req_ack   (l15_req_ack)
	);

	retire_detect #(.PC_W(PC_W)) u_retire
	(
		.clk       (clk),
		.nrst      (nrst),
		.commit_pc (commit_pc),
		.commit    (commit)
	);

	assign stall_mem = status.stall_mem;
	assign arb_eqmem = status.arb_eqmem;

endmodule

// File: logic/l15_pkg.sv
package l15_pkg;

	// Request types seen on the port, carried through untouched
	typedef enum logic [4:0]
	{
		load  = 5'd0,
		store = 5'd1,
		ifill = 5'd4	// Instruction fill from fetch
	} l15_rqtype_e;

	// Client to port request
	typedef struct packed
	{
		logic        val;		// Request valid
		l15_rqtype_e rqtype;
		logic [2:0]  size;		// Access size code
		logic [31:0] address;
		logic [63:0] data;		// Store data
	} l15_req_t;

	// Port to client response
	typedef struct packed
	{
		logic        val;		// Response valid
		logic [4:0]  returntype;	// Same 5 bits everywhere
		logic [63:0] data_0;
		logic [63:0] data_1;
	} l15_rsp_t;

	// Port acks back to the requester
	typedef struct packed
	{
		logic ack;
		logic header_ack;	// Header accepted by the port
	} l15_ack_t;

endpackage

// File: logic/port_arbiter.sv
module port_arbiter
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                mem_pending,	// Data op waits in issue
	input  logic                hold,		// Pipeline holding
	input  logic                fetch_waiting,	// Fetch expects a response
	input  logic                mem_op_done,	// One cycle pulse
	input  logic                l15_rsp_val,
	input  l15_pkg::l15_ack_t   l15_ack,
	output arb_pkg::arb_status_t status,
	output logic                dmem_finished
);
	import arb_pkg::*;

	arb_state_e state;
	logic stall_mem;
	logic arb_eqmem;

	// Ownership machine, one step per clock
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= arb_instr;	// Fetch owns the port after reset
			stall_mem <= 1'b0;
			arb_eqmem <= 1'b0;
		end
		else
		begin
			case (state)
				arb_instr:
				begin
					// Data op wants the port and pipeline is free to move
					if (mem_pending && !hold)
					begin
						state     <= arb_wait;
						stall_mem <= 1'b1;
					end
				end
				arb_wait:
				begin
					if (fetch_waiting && l15_rsp_val)	// Outstanding fill returned
						state <= arb_mem;
				end
				arb_mem:
				begin
					arb_eqmem <= 1'b1;
					stall_mem <= 1'b0;
					// Hand back only once no more data ops queue up
					if (mem_op_done && !mem_pending)
					begin
						state     <= arb_instr;
						arb_eqmem <= 1'b0;
					end
				end
				default:
				begin
					state <= arb_instr;	// Unused code, recover to fetch
				end
			endcase
		end
	end

	// Data access completes on a response or a store ack
	assign dmem_finished = (state == arb_mem) && (l15_rsp_val || l15_ack.ack);

	assign status.state     = state;
	assign status.stall_mem = stall_mem;
	assign status.arb_eqmem = arb_eqmem;

endmodule

// File: logic/port_router.sv
module port_router
(
	input  arb_pkg::arb_state_e state,		// Current port owner
	input  l15_pkg::l15_req_t   fetch_req,
	input  l15_pkg::l15_req_t   mem_req,
	input  logic                fetch_req_ack,	// Fetch consumed the response
	input  logic                mem_req_ack,	// Data side consumed the response
	input  l15_pkg::l15_ack_t   l15_ack,
	input  l15_pkg::l15_rsp_t   l15_rsp,
	output l15_pkg::l15_req_t   l15_req,
	output l15_pkg::l15_ack_t   fetch_ack,
	output l15_pkg::l15_ack_t   mem_ack,
	output l15_pkg::l15_rsp_t   fetch_rsp,
	output l15_pkg::l15_rsp_t   mem_rsp,
	output logic                l15_req_ack
);
	import arb_pkg::*;

	// Request side toward the port
	always_comb
	begin
		l15_req = '0;	// Wait state drops the request valid
		case (state)
			arb_instr:
			begin
				l15_req = fetch_req;
			end
			arb_mem:
			begin
				l15_req = mem_req;
			end
			default:
			begin
				l15_req = '0;
			end
		endcase
	end

	// Acks back to the clients
	always_comb
	begin
		fetch_ack = '0;
		mem_ack   = '0;
		case (state)
			arb_instr:
			begin
				fetch_ack = l15_ack;
			end
			arb_wait:
			begin
				// No header acks here, but a pending fill may still finish
				fetch_ack.ack = l15_ack.ack;
			end
			arb_mem:
			begin
				mem_ack = l15_ack;
			end
			default:
			begin
				fetch_ack = '0;
			end
		endcase
	end

	// Response side, fetch keeps it until data owns the port
	always_comb
	begin
		fetch_rsp   = '0;
		mem_rsp     = '0;
		l15_req_ack = fetch_req_ack;	// Same owner as the response
		case (state)
			arb_instr, arb_wait:
			begin
				fetch_rsp = l15_rsp;
			end
			arb_mem:
			begin
				mem_rsp     = l15_rsp;
				l15_req_ack = mem_req_ack;
			end
			default:
			begin
				fetch_rsp = '0;
			end
		endcase
	end

endmodule

// File: logic/retire_detect.sv
module retire_detect
#(
	parameter int PC_W = 32
)
(
	input  logic            clk,
	input  logic            nrst,
	input  logic [PC_W-1:0] commit_pc,	// Program counter at commit
	output logic            commit		// One cycle per new pc
);
	logic [PC_W-1:0] last_pc;	// Last captured commit pc

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			last_pc <= '0;
			commit  <= 1'b0;
		end
		else if (commit_pc != last_pc)
		begin
			commit  <= 1'b1;		// New instruction retired
			last_pc <= commit_pc;
		end
		else
			commit <= 1'b0;		// Repeat, nothing new
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the cache port share testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module tb_cache_port_share \
	-f verilog.f -Mdir obj_dir
./obj_dir/Vtb_cache_port_share > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log
if grep -qx "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tests/port_share_checker.sv
module port_share_checker
#(
	parameter int PC_W = 32
)
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              mem_pending, hold, fetch_waiting, mem_op_done,
	input  l15_pkg::l15_req_t fetch_req, mem_req,
	input  logic              fetch_req_ack, mem_req_ack,
	input  l15_pkg::l15_ack_t l15_ack,
	input  l15_pkg::l15_rsp_t l15_rsp,
	input  logic [PC_W-1:0]   commit_pc,
	input  l15_pkg::l15_req_t l15_req,	// DUT outputs from here on
	input  logic              l15_req_ack,
	input  l15_pkg::l15_ack_t fetch_ack, mem_ack,
	input  l15_pkg::l15_rsp_t fetch_rsp, mem_rsp,
	input  logic              stall_mem, arb_eqmem, dmem_finished, commit,
	output int                checks,
	output int                errors
);
	timeunit 1ns;
	timeprecision 1ns;
	import l15_pkg::*;
	import arb_pkg::*;

	arb_state_e      m_state;	// Model of the ownership machine
	logic            m_stall;
	logic            m_eqmem;
	logic            m_commit;
	logic [PC_W-1:0] m_last_pc;	// Model of the captured commit pc
	l15_req_t        exp_req;
	l15_ack_t        exp_fetch_ack;
	l15_ack_t        exp_mem_ack;
	l15_rsp_t        exp_fetch_rsp;
	l15_rsp_t        exp_mem_rsp;
	int              check_count = 0;
	int              error_count = 0;

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			m_state   <= arb_instr;
			m_stall   <= 1'b0;
			m_eqmem   <= 1'b0;
			m_commit  <= 1'b0;
			m_last_pc <= '0;
		end
		else
		begin
			if (m_state == arb_instr && mem_pending && !hold)
			begin
				m_state <= arb_wait;
				m_stall <= 1'b1;	// Issue stalls while fetch drains
			end
			if (m_state == arb_wait && fetch_waiting && l15_rsp.val)
				m_state <= arb_mem;
			if (m_state == arb_mem)
			begin
				m_stall <= 1'b0;
				m_eqmem <= !(mem_op_done && !mem_pending);	// Low again on hand back
				if (mem_op_done && !mem_pending)
					m_state <= arb_instr;
			end
			m_commit  <= (commit_pc != m_last_pc);	// Pulse only on a new pc
			m_last_pc <= commit_pc;
		end
	end

	// Expected routing, anything not owned stays zero
	always_comb
	begin
		exp_req       = '0;
		exp_fetch_ack = '0;
		exp_mem_ack   = '0;
		exp_fetch_rsp = l15_rsp;	// Fetch sees responses unless data owns
		exp_mem_rsp   = '0;
		if (m_state == arb_instr)
		begin
			exp_req       = fetch_req;
			exp_fetch_ack = l15_ack;
		end
		if (m_state == arb_wait)
			exp_fetch_ack.ack = l15_ack.ack;	// Outstanding fill may finish
		if (m_state == arb_mem)
		begin
			exp_req       = mem_req;
			exp_mem_ack   = l15_ack;
			exp_fetch_rsp = '0;
			exp_mem_rsp   = l15_rsp;
		end
	end

	task automatic compare(input string name, input logic [133:0] got, input logic [133:0] want);
		check_count++;
		if (got !== want)
		begin
			error_count++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	// Inputs settle in the low phase, compare before the edge moves state
	always @(posedge clk)
	begin
		if (nrst)
		begin
			compare("l15_req", 134'(l15_req), 134'(exp_req));
			compare("l15_req_ack", 134'(l15_req_ack),
				134'((m_state == arb_mem) ? mem_req_ack : fetch_req_ack));
			compare("fetch_ack", 134'(fetch_ack), 134'(exp_fetch_ack));
			compare("mem_ack", 134'(mem_ack), 134'(exp_mem_ack));
			compare("fetch_rsp", 134'(fetch_rsp), 134'(exp_fetch_rsp));
			compare("mem_rsp", 134'(mem_rsp), 134'(exp_mem_rsp));
			compare("stall_mem", 134'(stall_mem), 134'(m_stall));
			compare("arb_eqmem", 134'(arb_eqmem), 134'(m_eqmem));
			compare("dmem_finished", 134'(dmem_finished),
				134'((m_state == arb_mem) && (l15_rsp.val || l15_ack.ack)));
			compare("commit", 134'(commit), 134'(m_commit));
		end
	end

	assign checks = check_count;
	assign errors = error_count;

endmodule

// File: tests/port_share_sva.sv
module port_share_sva
(
	input logic                 clk,
	input logic                 nrst,
	input arb_pkg::arb_status_t status	// Arbiter status inside port_arbiter
);
	timeunit 1ns;
	timeprecision 1ns;
	import arb_pkg::*;

	int fail_count = 0;	// Read by the testbench top at the end

	// Only three of the four codes are used
	state_legal: assert property (@(posedge clk) disable iff (!nrst)
		status.state inside {arb_instr, arb_wait, arb_mem})
	else
	begin
		fail_count++;
		$error("Arbiter state outside the three legal codes");
	end

	// Data ownership never overlaps with the issue stall
	eqmem_no_stall: assert property (@(posedge clk) disable iff (!nrst)
		status.arb_eqmem |-> !status.stall_mem)
	else
	begin
		fail_count++;
		$error("arb_eqmem and stall_mem high together");
	end

	wait_from_instr: assert property (@(posedge clk) disable iff (!nrst)
		($changed(status.state) && status.state == arb_wait) |-> $past(status.state) == arb_instr)
	else
	begin
		fail_count++;
		$error("Wait state entered from a state other than arb_instr");
	end

endmodule

// File: tests/tb_cache_port_share.sv
module tb_cache_port_share;
	timeunit 1ns;
	timeprecision 1ns;
	import l15_pkg::*;

	localparam int PC_W           = 32;
	localparam int TB_SEED        = 90;
	localparam int N_ROWS         = 22;
	localparam int TIMEOUT_CYCLES = N_ROWS + 20;	// Reset and tail fit well inside

	// One cycle of control levels and port activity tags
	typedef struct packed
	{
		logic            mem_pending;
		logic            hold;
		logic            fetch_waiting;
		logic            mem_op_done;
		logic            rsp_val;
		logic            ack;
		logic            header_ack;
		logic [PC_W-1:0] pc;
	} stim_row_t;

	// pending, hold, fetch_waiting, op_done, rsp_val, ack, header_ack, commit_pc
	stim_row_t rows [N_ROWS] = '{
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h00},	// Fetch owns after reset
		'{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 32'h00},
		'{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h04},	// Hold blocks the switch
		'{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 32'h04},
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h08},	// Into wait
		'{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h08},	// Header acks withheld
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0c},
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0c},	// Fill returns, data takes over
		'{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0c},
		'{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h10},	// Finished by response
		'{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 32'h10},	// Finished by ack
		'{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h14},	// Done but more pending
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h14},
		'{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 32'h18},	// Hand back to fetch
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 32'h18},
		'{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h18},
		'{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1c},	// Second round
		'{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1c},
		'{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h20},	// Leaves data on its first cycle
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h20},
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h00},	// Back to zero is a change too
		'{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h00}
	};

	logic            clk = 1'b0;
	logic            nrst;
	logic            mem_pending, hold, fetch_waiting, mem_op_done;
	logic            fetch_req_ack, mem_req_ack;
	l15_req_t        fetch_req, mem_req, l15_req;
	l15_ack_t        l15_ack, fetch_ack, mem_ack;
	l15_rsp_t        l15_rsp, fetch_rsp, mem_rsp;
	logic [PC_W-1:0] commit_pc;
	logic            l15_req_ack, stall_mem, arb_eqmem, dmem_finished, commit;
	int              checks, errors;
	int              sva_fails;
	int              cycles = 0;

	cache_port_share #(.PC_W(PC_W)) UUT (.*);

	port_share_checker #(.PC_W(PC_W)) u_checker (.*);

	bind port_arbiter port_share_sva arb_sva (.clk(clk), .nrst(nrst), .status(status));

	always #5 clk = ~clk;	// 10 ns period

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Control levels from the row, payloads random
	task automatic drive_row(input stim_row_t r, input int idx);
		mem_pending        = r.mem_pending;
		hold               = r.hold;
		fetch_waiting      = r.fetch_waiting;
		mem_op_done        = r.mem_op_done;
		fetch_req.val      = 1'($urandom);
		fetch_req.rqtype   = ifill;
		fetch_req.size     = 3'($urandom);
		fetch_req.address  = $urandom;
		fetch_req.data     = {$urandom, $urandom};
		mem_req.val        = 1'($urandom);
		mem_req.rqtype     = idx[0] ? store : load;	// Alternate loads and stores
		mem_req.size       = 3'($urandom);
		mem_req.address    = $urandom;
		mem_req.data       = {$urandom, $urandom};
		l15_rsp.val        = r.rsp_val;
		l15_rsp.returntype = 5'($urandom);
		l15_rsp.data_0     = {$urandom, $urandom};
		l15_rsp.data_1     = {$urandom, $urandom};
		l15_ack.ack        = r.ack;
		l15_ack.header_ack = r.header_ack;
		fetch_req_ack      = 1'($urandom);
		mem_req_ack        = 1'($urandom);
		commit_pc          = r.pc;
	endtask

	initial
	begin
		void'($urandom(TB_SEED));
		nrst = 1'b0;
		drive_row('0, 0);	// Every input known from time zero
		repeat (2) @(negedge clk);
		nrst = 1'b1;
		for (int i = 0; i < N_ROWS; i++)
		begin
			drive_row(rows[i], i);
			@(negedge clk);
		end
		drive_row('0, N_ROWS);	// Idle row so the last pulse gets checked
		@(negedge clk);
		sva_fails = UUT.u_arbiter.arb_sva.fail_count;
		$display("Checks %0d, value errors %0d, assertion failures %0d", checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verilog.f
logic/l15_pkg.sv
logic/arb_pkg.sv
logic/port_arbiter.sv
logic/port_router.sv
logic/retire_detect.sv
logic/cache_port_share.sv
tests/port_share_sva.sv
tests/port_share_checker.sv
tests/tb_cache_port_share.sv
